/* include/pwm_defs.svh */
// Build-time sizes and reset values of the PWM generator
// Counter width, chain and channel counts, output count
// Register address width and the stopped-state pattern after reset
`ifndef PWM_DEFS_SVH
`define PWM_DEFS_SVH

// Width of the period counter and of every compare value
`define PWM_COUNTER_WIDTH 16

// Two chains with two channels each
`define PWM_N_CHAINS 2
`define PWM_N_CHANNELS 2

// Every channel drives a complementary pair, so four outputs per chain
`define PWM_N_OUTPUTS 8

// Word address width of the register write port
`define PWM_ADDR_WIDTH 4

// Pattern driven on every output after reset until software writes one
`define PWM_INITIAL_STOPPED 8'h00

`endif

/* rtl/pwm_chain.sv */
// One PWM chain
// Period counter advanced by the timebase tick and cleared by sync,
// one comparator per channel and registered complementary outputs
// that fall back to the stopped pattern while the chain is disabled
`timescale 1ns/1ns
`default_nettype none

`include "pwm_defs.svh"

module pwm_chain (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             sync,
    input  wire                             tick,
    input  wire                             output_enable,
    input  wire pwm_types_pkg::counter_t    period,
    // Compare value of channel 0
    input  wire pwm_types_pkg::counter_t    compare_a,
    // Compare value of channel 1
    input  wire pwm_types_pkg::counter_t    compare_b,
    input  wire [`PWM_N_CHANNELS-1:0]       stopped_a,
    input  wire [`PWM_N_CHANNELS-1:0]       stopped_b,
    output logic [`PWM_N_CHANNELS-1:0]      out_a,
    output logic [`PWM_N_CHANNELS-1:0]      out_b
);

    pwm_types_pkg::counter_t          counter;
    logic                             at_wrap;
    logic [`PWM_N_CHANNELS-1:0]       below;

    // Last count of the period, the counter returns to zero after it
    assign at_wrap = counter >= (period - pwm_types_pkg::counter_t'(1));

    // The counter never exceeds period minus 1, so a compare at or above
    // the period keeps out_a high for the whole period
    assign below[0] = counter < compare_a;
    assign below[1] = counter < compare_b;

    always_ff @(posedge clock) begin
        if (!reset) begin
            counter <= '0;
        end else if (sync) begin
            counter <= '0;
        end else if (tick) begin
            if (at_wrap) begin
                counter <= '0;
            end else begin
                counter <= counter + pwm_types_pkg::counter_t'(1);
            end
        end
    end

    // Outputs follow the counter one cycle late
    // While disabled, and during reset, they hold the stopped pattern
    always_ff @(posedge clock) begin
        if (!reset || !output_enable) begin
            out_a <= stopped_a;
            out_b <= stopped_b;
        end else begin
            out_a <= below;
            out_b <= ~below;
        end
    end

endmodule

`default_nettype wire

/* rtl/pwm_control_unit.sv */
// Run, stop and fault state machine of the PWM generator
// Emits the counter sync pulse on entry to RUNNING and the per-chain
// output enables, which drop at once while fault is high
`timescale 1ns/1ns
`default_nettype none

`include "pwm_defs.svh"

module pwm_control_unit (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             run_request,
    input  wire                             fault,
    input  wire                             fault_clear,
    input  wire [`PWM_N_CHAINS-1:0]         chain_enable,
    output logic                            sync,
    output logic [`PWM_N_CHAINS-1:0]        output_enable,
    output pwm_state_pkg::control_state_t   state
);

    pwm_state_pkg::control_state_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            pwm_state_pkg::STOPPED: begin
                if (run_request) begin
                    next_state = pwm_state_pkg::RUNNING;
                end
            end
            pwm_state_pkg::RUNNING: begin
                if (!run_request) begin
                    next_state = pwm_state_pkg::STOPPED;
                end
            end
            pwm_state_pkg::FAULTED: begin
                // Leaving the fault needs the input gone and a clear from software
                if (!fault && fault_clear) begin
                    next_state = pwm_state_pkg::STOPPED;
                end
            end
            default: next_state = pwm_state_pkg::STOPPED;
        endcase
        // A fault wins over every other transition
        if (fault) begin
            next_state = pwm_state_pkg::FAULTED;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= pwm_state_pkg::STOPPED;
            sync  <= 1'b0;
        end else begin
            state <= next_state;
            // Sync is high during the first RUNNING cycle only
            sync  <= (state != pwm_state_pkg::RUNNING) &&
                     (next_state == pwm_state_pkg::RUNNING);
        end
    end

    // The fault input gates the enables directly so the chains fall back
    // to the stopped pattern on the very next edge
    always_comb begin
        for (int i = 0; i < `PWM_N_CHAINS; i++) begin
            output_enable[i] = (state == pwm_state_pkg::RUNNING) && chain_enable[i] && !fault;
        end
    end

endmodule

`default_nettype wire

/* rtl/pwm_generator.sv */
// Top level of the PWM generator
// Register file, control state machine, timebase and two PWM chains,
// with the chain outputs packed into the pwm_out word
`timescale 1ns/1ns
`default_nettype none

`include "pwm_defs.svh"

module pwm_generator (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             reg_write,
    input  wire pwm_types_pkg::reg_addr_t   reg_addr,
    input  wire pwm_types_pkg::reg_data_t   reg_data,
    input  wire                             fault,
    input  wire                             ext_timebase,
    output logic                            timebase,
    output pwm_types_pkg::pwm_word_t        pwm_out
);

    localparam int HALF = 2 * `PWM_N_CHANNELS;

    logic                               run_request;
    logic                               fault_clear;
    logic                               external_select;
    pwm_types_pkg::divider_t            divider;
    logic [`PWM_N_CHAINS-1:0]           chain_enable;
    pwm_types_pkg::pwm_word_t           stopped_state;
    pwm_types_pkg::counter_t            period [`PWM_N_CHAINS];
    pwm_types_pkg::counter_t            compare [2*`PWM_N_CHAINS];
    logic                               sync;
    logic [`PWM_N_CHAINS-1:0]           output_enable;
    pwm_state_pkg::control_state_t      state;
    logic                               tick;
    pwm_types_pkg::chain_half_t         chain_stopped [`PWM_N_CHAINS];
    pwm_types_pkg::chain_half_t         chain_out [`PWM_N_CHAINS];

    pwm_register_file registers (
        .clock(clock), .reset(reset),
        .reg_write(reg_write), .reg_addr(reg_addr), .reg_data(reg_data),
        .run_request(run_request), .fault_clear(fault_clear),
        .external_select(external_select), .divider(divider),
        .chain_enable(chain_enable), .stopped_state(stopped_state),
        .period_0(period[0]), .period_1(period[1]),
        .compare_0(compare[0]), .compare_1(compare[1]),
        .compare_2(compare[2]), .compare_3(compare[3])
    );

    pwm_control_unit control (
        .clock(clock), .reset(reset),
        .run_request(run_request), .fault(fault), .fault_clear(fault_clear),
        .chain_enable(chain_enable),
        .sync(sync), .output_enable(output_enable), .state(state)
    );

    // The divider only runs once the chains have left STOPPED
    timebase_generator timebase_gen (
        .clock(clock), .reset(reset),
        .enable(state != pwm_state_pkg::STOPPED),
        .divider(divider), .external_select(external_select),
        .ext_timebase(ext_timebase),
        .tick(tick), .internal_tick(timebase)
    );

    for (genvar i = 0; i < `PWM_N_CHAINS; i++) begin : chains
        // Each chain owns a slice of the stopped pattern and of pwm_out
        assign chain_stopped[i] = stopped_state[i*HALF +: HALF];
        assign pwm_out[i*HALF +: HALF] = chain_out[i];

        pwm_chain chain (
            .clock(clock), .reset(reset),
            .sync(sync), .tick(tick), .output_enable(output_enable[i]),
            .period(period[i]),
            .compare_a(compare[2*i]), .compare_b(compare[2*i+1]),
            .stopped_a(chain_stopped[i][`PWM_N_CHANNELS-1:0]),
            .stopped_b(chain_stopped[i][HALF-1:`PWM_N_CHANNELS]),
            .out_a(chain_out[i][`PWM_N_CHANNELS-1:0]),
            .out_b(chain_out[i][HALF-1:`PWM_N_CHANNELS])
        );
    end

endmodule

`default_nettype wire

/* rtl/pwm_register_file.sv */
// Settings registers of the PWM generator
// Decodes the write port into control, stopped pattern, enable mask,
// periods and compare values, and makes the fault clear pulse
`timescale 1ns/1ns
`default_nettype none

`include "pwm_defs.svh"

module pwm_register_file (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         reg_write,
    input  wire pwm_types_pkg::reg_addr_t reg_addr,
    input  wire pwm_types_pkg::reg_data_t reg_data,
    output logic                        run_request,
    output logic                        fault_clear,
    output logic                        external_select,
    output pwm_types_pkg::divider_t     divider,
    output logic [`PWM_N_CHAINS-1:0]    chain_enable,
    output pwm_types_pkg::pwm_word_t    stopped_state,
    output pwm_types_pkg::counter_t     period_0,
    output pwm_types_pkg::counter_t     period_1,
    output pwm_types_pkg::counter_t     compare_0,
    output pwm_types_pkg::counter_t     compare_1,
    output pwm_types_pkg::counter_t     compare_2,
    output pwm_types_pkg::counter_t     compare_3
);

    always_ff @(posedge clock) begin
        if (!reset) begin
            run_request     <= 1'b0;
            fault_clear     <= 1'b0;
            external_select <= 1'b0;
            divider         <= '0;
            chain_enable    <= '0;
            stopped_state   <= `PWM_INITIAL_STOPPED;
            period_0        <= '0;
            period_1        <= '0;
            compare_0       <= '0;
            compare_1       <= '0;
            compare_2       <= '0;
            compare_3       <= '0;
        end else begin
            // Fault clear lasts one cycle, whatever was written
            fault_clear <= 1'b0;
            if (reg_write) begin
                case (reg_addr)
                    // Control word: run, fault clear, timebase select, divider
                    'd0: begin
                        run_request     <= reg_data[0];
                        fault_clear     <= reg_data[1];
                        external_select <= reg_data[2];
                        divider         <= reg_data[5:3];
                    end
                    'd1: stopped_state <= reg_data[`PWM_N_OUTPUTS-1:0];
                    'd2: chain_enable  <= reg_data[`PWM_N_CHAINS-1:0];
                    'd3: period_0      <= reg_data;
                    'd4: period_1      <= reg_data;
                    // Chain 0 compares, then chain 1 compares
                    'd5: compare_0     <= reg_data;
                    'd6: compare_1     <= reg_data;
                    'd7: compare_2     <= reg_data;
                    'd8: compare_3     <= reg_data;
                    // Unused addresses leave every register as it is
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/pwm_state_pkg.sv */
// State encoding of the PWM control state machine
`default_nettype none

package pwm_state_pkg;

    // Chains are held in STOPPED until a run request arrives
    // FAULTED is left only through an explicit fault clear
    typedef enum logic [1:0] {
        STOPPED = 2'd0,
        RUNNING = 2'd1,
        FAULTED = 2'd2
    } control_state_t;

endpackage

`default_nettype wire

/* rtl/pwm_types_pkg.sv */
// Vector types shared by the PWM generator
// Counter values, output words, divider exponent, register address and data
`default_nettype none

`include "pwm_defs.svh"

package pwm_types_pkg;

    // Counter, period and compare values all share this width
    typedef logic [`PWM_COUNTER_WIDTH-1:0] counter_t;

    // One bit for each PWM output pin
    typedef logic [`PWM_N_OUTPUTS-1:0] pwm_word_t;

    // Outputs of a single chain, out_a bits low and out_b bits high
    typedef logic [2*`PWM_N_CHANNELS-1:0] chain_half_t;

    // The timebase divides the clock by 2 to the power of this value
    typedef logic [2:0] divider_t;

    typedef logic [`PWM_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [15:0] reg_data_t;

endpackage

`default_nettype wire

/* rtl/timebase_generator.sv */
// Timebase of the PWM chains
// Power-of-two divider of the clock and a synchronized edge detector
// on the external timebase input, selected into a one-cycle tick
`timescale 1ns/1ns
`default_nettype none

module timebase_generator (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         enable,
    input  wire pwm_types_pkg::divider_t divider,
    input  wire                         external_select,
    input  wire                         ext_timebase,
    output logic                        tick,
    output logic                        internal_tick
);

    // Wide enough for the largest exponent of the divider
    logic [7:0] divide_count;
    logic [7:0] divide_mask;
    logic       divide_hit;

    // Two flip-flops for metastability and a third one for the edge
    logic [2:0] ext_sync;
    logic       ext_edge;

    // With divider 0 the mask is empty and every cycle is a hit
    assign divide_mask = (8'd1 << divider) - 8'd1;
    assign divide_hit  = (divide_count & divide_mask) == divide_mask;
    assign ext_edge    = ext_sync[1] && !ext_sync[2];

    always_ff @(posedge clock) begin
        if (!reset) begin
            divide_count  <= '0;
            ext_sync      <= '0;
            tick          <= 1'b0;
            internal_tick <= 1'b0;
        end else begin
            ext_sync <= {ext_sync[1:0], ext_timebase};
            // The divider restarts from zero each time the chains are started
            if (enable) begin
                divide_count <= divide_count + 8'd1;
            end else begin
                divide_count <= '0;
            end
            internal_tick <= enable && divide_hit;
            tick          <= enable && (external_select ? ext_edge : divide_hit);
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the PWM generator testbench with Verilator and runs it.
# The run passes only if the testbench printed its pass line.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module pwm_generator_tb -o pwm_sim
output=$(./obj_dir/pwm_sim)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "Regression passed"

/* testbench/clock_gen.sv */
// Clock and reset source of the PWM generator testbench
// 40 ns clock, active-low reset held for the first 5 rising edges
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever begin
            #20;
            clock = ~clock;
        end
    end

    // Reset is released just after an edge, like every other input
    initial begin
        reset = 1'b0;
        repeat (5) @(posedge clock);
        #5;
        reset = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/pwm_generator_props.sv */
// Assertions on the PWM generator control signals
// Fault gating of the output enables, sync pulse width and placement,
// and the width of the timebase tick
`timescale 1ns/1ns
`default_nettype none

`include "pwm_defs.svh"

module pwm_generator_props (
    input wire                              clock,
    input wire                              reset,
    input wire                              fault,
    input wire                              sync,
    input wire                              tick,
    input wire pwm_types_pkg::divider_t     divider,
    input wire                              external_select,
    input wire [`PWM_N_CHAINS-1:0]          output_enable,
    input wire pwm_state_pkg::control_state_t state
);

    // No chain may stay enabled while the fault input is high
    fault_gates_enables: assert property (@(posedge clock) disable iff (!reset)
        fault |-> (output_enable == '0))
        else $error("output enable high while fault is asserted");

    // A fault reaches the state register on the next edge
    fault_enters_faulted: assert property (@(posedge clock) disable iff (!reset)
        fault |=> (state == pwm_state_pkg::FAULTED))
        else $error("state did not move to FAULTED after a fault");

    // Sync is a single-cycle pulse, and only in the first RUNNING cycle
    sync_single_cycle: assert property (@(posedge clock) disable iff (!reset)
        sync |=> !sync)
        else $error("sync pulse longer than one cycle");
    sync_in_running: assert property (@(posedge clock) disable iff (!reset)
        sync |-> (state == pwm_state_pkg::RUNNING))
        else $error("sync pulse outside RUNNING");

    // Only the internal divide-by-one mode may tick on back-to-back cycles
    // Settings that change between two ticks are left out
    tick_single_cycle: assert property (@(posedge clock) disable iff (!reset)
        (tick && $stable(divider) && $stable(external_select) &&
         (external_select || (divider != '0))) |=> !tick)
        else $error("timebase tick longer than one cycle");

endmodule

// Attached at the top level, where the tick and the control signals meet
bind pwm_generator pwm_generator_props props (
    .clock(clock), .reset(reset), .fault(fault), .sync(sync), .tick(tick),
    .divider(divider), .external_select(external_select),
    .output_enable(output_enable), .state(state)
);

`default_nettype wire

/* testbench/pwm_generator_tb.sv */
// Testbench of the PWM generator
// Table of divider, periods, compares and expected high counts applied in a loop,
// then stop, fault, chain enable mask and external timebase checks
`timescale 1ns/1ns
`default_nettype none

`include "pwm_defs.svh"

module pwm_generator_tb;

    logic                       clock;
    logic                       reset;
    logic                       reg_write;
    pwm_types_pkg::reg_addr_t   reg_addr;
    pwm_types_pkg::reg_data_t   reg_data;
    logic                       fault;
    logic                       ext_timebase;
    logic                       timebase;
    pwm_types_pkg::pwm_word_t   pwm_out;
    logic                       ext_active;
    int                         ext_phase;
    int                         errors;
    int                         checks;
    integer                     seed;

    // Expected out_a high cycles are min(compare, period) times 2 to the divider
    int table_div [4] = '{0, 1, 2, 3};
    int table_period [4][2] = '{'{10, 8}, '{6, 5}, '{4, 7}, '{3, 2}};
    int table_compare [4][4] = '{'{3, 7, 2, 8}, '{0, 4, 9, 1}, '{2, 4, 3, 6}, '{1, 2, 1, 5}};
    int table_expected [4][4] = '{'{3, 7, 2, 8}, '{0, 8, 10, 2}, '{8, 16, 12, 24},
                                  '{8, 16, 8, 16}};

    clock_gen clocks (.clock(clock), .reset(reset));

    pwm_generator UUT (
        .clock(clock), .reset(reset),
        .reg_write(reg_write), .reg_addr(reg_addr), .reg_data(reg_data),
        .fault(fault), .ext_timebase(ext_timebase),
        .timebase(timebase), .pwm_out(pwm_out)
    );

    // External timebase: a rising edge every 6 cycles while active
    initial begin
        ext_timebase = 1'b0;
        ext_phase = 0;
        forever begin
            @(posedge clock);
            #5;
            ext_phase = (ext_active && ext_phase < 5) ? ext_phase + 1 : 0;
            ext_timebase = ext_active && (ext_phase < 3);
        end
    end

    // Every task starts and ends 5 ns after a rising edge
    task automatic step();
        @(posedge clock);
        #5;
    endtask

    task automatic write_reg(input int addr, input int data);
        reg_write = 1'b1;
        reg_addr = pwm_types_pkg::reg_addr_t'(addr);
        reg_data = pwm_types_pkg::reg_data_t'(data);
        step();
        reg_write = 1'b0;
    endtask

    // Control register: run, fault clear, external select, divider in bits 5 to 3
    function automatic int control_word(input int run, input int clear, input int ext,
                                        input int div);
        return run | (clear << 1) | (ext << 2) | (div << 3);
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("mismatch %s: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic load_entry(input int e);
        write_reg(3, table_period[e][0]);
        write_reg(4, table_period[e][1]);
        for (int k = 0; k < 4; k++) begin
            write_reg(5 + k, table_compare[e][k]);
        end
    endtask

    // Counts high cycles of one chain's four outputs over a full period window
    task automatic measure_chain(input string name, input int chain, input int scale,
                                 input int period, input int exp_a0, input int exp_a1);
        int window;
        int high [4];
        window = scale * period;
        high = '{0, 0, 0, 0};
        repeat (window) begin
            step();
            for (int b = 0; b < 4; b++) begin
                if (pwm_out[chain * 4 + b]) begin
                    high[b]++;
                end
            end
        end
        check_value({name, " out_a0"}, exp_a0, high[0]);
        check_value({name, " out_a1"}, exp_a1, high[1]);
        check_value({name, " out_b0"}, window - exp_a0, high[2]);
        check_value({name, " out_b1"}, window - exp_a1, high[3]);
    endtask

    task automatic wait_for_pattern(input string name, input pwm_types_pkg::pwm_word_t pattern,
                                    input int limit);
        int cycles;
        cycles = 0;
        while (pwm_out !== pattern && cycles < limit) begin
            step();
            cycles++;
        end
        checks++;
        if (pwm_out !== pattern) begin
            errors++;
            $display("mismatch %s: expected %h actual %h", name, pattern, pwm_out);
        end
    endtask

    // The masked bits must keep the pattern in every cycle
    task automatic check_hold(input string name, input pwm_types_pkg::pwm_word_t mask,
                              input pwm_types_pkg::pwm_word_t pattern, input int cycles);
        checks++;
        repeat (cycles) begin
            step();
            if ((pwm_out & mask) !== (pattern & mask)) begin
                errors++;
                $display("mismatch %s: expected %h actual %h", name, pattern & mask,
                         pwm_out & mask);
                return;
            end
        end
    endtask

    initial begin
        int cycles;
        int scale;
        pwm_types_pkg::pwm_word_t stopped;
        reg_write = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        fault = 1'b0;
        ext_active = 1'b0;
        errors = 0;
        checks = 0;
        seed = 32'h44483321;
        cycles = 0;
        while (reset !== 1'b1 && cycles < 20) begin
            @(posedge clock);
            cycles++;
        end
        #5;
        if (reset !== 1'b1) begin
            errors++;
            $display("reset was never released");
        end

        // After reset the outputs idle and the timebase pin stays quiet
        check_hold("reset pattern", 8'hff, `PWM_INITIAL_STOPPED, 10);
        checks++;
        if (timebase !== 1'b0) begin
            errors++;
            $display("mismatch reset timebase: expected 0 actual %b", timebase);
        end
        write_reg(2, 3);

        for (int e = 0; e < 4; e++) begin
            stopped = pwm_types_pkg::pwm_word_t'($random(seed));
            write_reg(1, int'(stopped));
            load_entry(e);
            write_reg(0, control_word(1, 0, 0, table_div[e]));
            scale = 1 << table_div[e];
            // Let both counters run through more than a full period
            repeat (scale * (table_period[e][0] + table_period[e][1]) + 8) step();
            measure_chain($sformatf("entry %0d chain 0", e), 0, scale, table_period[e][0],
                          table_expected[e][0], table_expected[e][1]);
            measure_chain($sformatf("entry %0d chain 1", e), 1, scale, table_period[e][1],
                          table_expected[e][2], table_expected[e][3]);
            write_reg(0, control_word(0, 0, 0, table_div[e]));
            wait_for_pattern($sformatf("entry %0d stop", e), stopped, 2);
        end

        // A fault drops every output to the stopped pattern on the next edge
        stopped = pwm_types_pkg::pwm_word_t'($random(seed));
        write_reg(1, int'(stopped));
        load_entry(0);
        write_reg(0, control_word(1, 0, 0, 0));
        repeat (20) step();
        fault = 1'b1;
        step();
        check_value("fault entry", int'(stopped), int'(pwm_out));
        check_hold("fault held", 8'hff, stopped, 4);
        fault = 1'b0;
        // Run is still requested but FAULTED waits for a clear
        check_hold("fault released", 8'hff, stopped, 12);
        write_reg(0, control_word(1, 1, 0, 0));
        repeat (20) step();
        measure_chain("fault recovery chain 0", 0, 1, 10, 3, 7);

        // Chain 1 masked off while chain 0 keeps running
        write_reg(2, 1);
        repeat (2) step();
        measure_chain("mask chain 0", 0, 1, 10, 3, 7);
        check_hold("mask chain 1", 8'hf0, stopped, 16);
        write_reg(2, 3);
        write_reg(0, control_word(0, 0, 0, 0));
        wait_for_pattern("mask stop", stopped, 2);

        // External timebase, one counter step per edge every 6 cycles
        stopped = pwm_types_pkg::pwm_word_t'($random(seed));
        write_reg(1, int'(stopped));
        write_reg(3, 5);
        write_reg(4, 4);
        write_reg(5, 2);
        write_reg(6, 4);
        write_reg(7, 1);
        write_reg(8, 6);
        ext_active = 1'b1;
        write_reg(0, control_word(1, 0, 1, 0));
        repeat (6 * 9 + 12) step();
        measure_chain("external chain 0", 0, 6, 5, 12, 24);
        measure_chain("external chain 1", 1, 6, 4, 6, 24);
        write_reg(0, control_word(0, 0, 1, 0));
        wait_for_pattern("external stop", stopped, 2);
        ext_active = 1'b0;

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
rtl/pwm_types_pkg.sv
rtl/pwm_state_pkg.sv
rtl/pwm_register_file.sv
rtl/pwm_control_unit.sv
rtl/timebase_generator.sv
rtl/pwm_chain.sv
rtl/pwm_generator.sv
testbench/clock_gen.sv
testbench/pwm_generator_props.sv
testbench/pwm_generator_tb.sv
